// File: hw/wb_stream_pkg.sv
package wb_stream_pkg;

    // wishbone data width, also the sample width on both streams
    localparam int DATA_W = 32;

    // compared against the low address byte only
    localparam logic [7:0] X_PORT_OFFSET = 8'h80;
    localparam logic [7:0] Y_PORT_OFFSET = 8'h84;

    typedef logic [DATA_W-1:0] sample_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        sample_t     dat;
    } wb_req_t;

    typedef struct packed {
        sample_t data;
        logic    last;
    } ss_beat_t;

    typedef enum logic [1:0] {
        PORT_NONE,
        PORT_X,
        PORT_Y
    } port_sel_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_WAIT,
        CTRL_ACK
    } ctrl_state_e;

endpackage

// File: hw/x_sample_buffer.sv
module x_sample_buffer #(
    parameter int FRAME_LEN = 64
) (
    input  logic                    wb_clk_i,
    input  logic                    wb_rst_i,
    input  logic                    push_i,
    input  wb_stream_pkg::sample_t  data_i,
    input  logic                    ss_tready_i,
    output logic                    empty_o,
    output wb_stream_pkg::ss_beat_t ss_beat_o,
    output logic                    ss_tvalid_o
);
    import wb_stream_pkg::*;

    localparam int CNT_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;

    logic             valid_q;
    logic             last_q;
    sample_t          data_q;
    logic [CNT_W-1:0] beat_cnt;   // beats done in current frame
    logic             handshake;

    assign handshake = valid_q && ss_tready_i;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            valid_q  <= 1'b0;
            last_q   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (push_i) begin
                valid_q <= 1'b1;
                last_q  <= (beat_cnt == CNT_W'(FRAME_LEN - 1));
            end else if (handshake) begin
                valid_q <= 1'b0;
                if (beat_cnt == CNT_W'(FRAME_LEN - 1)) begin
                    beat_cnt <= '0;   // wrap after last beat
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (push_i) begin
            data_q <= data_i;
        end
    end

    assign empty_o     = !valid_q;
    assign ss_tvalid_o = valid_q;
    assign ss_beat_o   = '{data: data_q, last: last_q};

    // controller must wait for room
    push_only_when_empty: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        push_i |-> empty_o
    );

endmodule

// File: hw/y_sample_buffer.sv
module y_sample_buffer (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   sm_tvalid_i,
    input  wb_stream_pkg::sample_t sm_tdata_i,
    input  logic                   pop_i,
    output logic                   sm_tready_o,
    output logic                   full_o,
    output wb_stream_pkg::sample_t data_o
);
    import wb_stream_pkg::*;

    logic    full_q;
    sample_t data_q;
    logic    capture;

    assign sm_tready_o = !full_q;   // ready whenever empty
    assign capture     = sm_tvalid_i && sm_tready_o;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (pop_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (capture) begin
            data_q <= sm_tdata_i;
        end
    end

    assign full_o = full_q;
    assign data_o = data_q;

    // reads are only started once a sample is here
    pop_only_when_full: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        pop_i |-> full_o
    );

endmodule

// File: hw/wb_port_ctrl.sv
module wb_port_ctrl #(
    parameter int ACK_DELAY = 10
) (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  wb_stream_pkg::wb_req_t req_i,
    input  logic                   x_empty_i,
    input  logic                   y_full_i,
    input  wb_stream_pkg::sample_t y_data_i,
    output logic                   ack_o,
    output wb_stream_pkg::sample_t dat_o,
    output logic                   x_push_o,
    output wb_stream_pkg::sample_t x_data_o,
    output logic                   y_pop_o
);
    import wb_stream_pkg::*;

    localparam int CNT_W = (ACK_DELAY > 0) ? $clog2(ACK_DELAY + 1) : 1;

    ctrl_state_e      state;
    port_sel_e        port_dec;
    port_sel_e        port_q;     // port of the access in flight
    logic             port_rdy;
    logic             accept;
    logic [CNT_W-1:0] delay_cnt;
    sample_t          wr_data;

    // low address byte picks the port
    always_comb begin
        port_dec = PORT_NONE;
        if (req_i.cyc && req_i.stb) begin
            if (req_i.adr[7:0] == X_PORT_OFFSET) begin
                port_dec = PORT_X;
            end else if (req_i.adr[7:0] == Y_PORT_OFFSET) begin
                port_dec = PORT_Y;
            end
        end
    end

    // x needs room and y needs a sample
    assign port_rdy = ((port_dec == PORT_X) && x_empty_i) ||
                      ((port_dec == PORT_Y) && y_full_i);
    assign accept   = (state == CTRL_IDLE) && port_rdy;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state     <= CTRL_IDLE;
            port_q    <= PORT_NONE;
            delay_cnt <= '0;
            ack_o     <= 1'b0;
            dat_o     <= '0;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (accept) begin
                        state     <= CTRL_WAIT;
                        port_q    <= port_dec;
                        delay_cnt <= '0;
                    end
                end
                CTRL_WAIT: begin
                    if (delay_cnt == CNT_W'(ACK_DELAY)) begin
                        state <= CTRL_ACK;
                        ack_o <= 1'b1;
                        // buffer stays full until our own pop
                        dat_o <= (port_q == PORT_Y) ? y_data_i : '0;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                CTRL_ACK: begin
                    state  <= CTRL_IDLE;
                    port_q <= PORT_NONE;
                    ack_o  <= 1'b0;
                    dat_o  <= '0;
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // write data held from acceptance
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            wr_data <= req_i.dat;
        end
    end

    assign x_data_o = wr_data;
    assign x_push_o = (state == CTRL_ACK) && (port_q == PORT_X);
    assign y_pop_o  = (state == CTRL_ACK) && (port_q == PORT_Y);

    // one ack pulse per accepted access
    ack_single_cycle: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        accept |-> ##(ACK_DELAY + 2) ack_o ##1 !ack_o
    );

endmodule

// File: hw/wb_stream_bridge.sv
module wb_stream_bridge #(
    parameter int ACK_DELAY = 10,
    parameter int FRAME_LEN = 64
) (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_we_i,
    input  logic [3:0]             wbs_sel_i,
    input  logic [31:0]            wbs_adr_i,
    input  wb_stream_pkg::sample_t wbs_dat_i,
    output logic                   wbs_ack_o,
    output wb_stream_pkg::sample_t wbs_dat_o,
    output logic                   ss_tvalid_o,
    output wb_stream_pkg::sample_t ss_tdata_o,
    output logic                   ss_tlast_o,
    input  logic                   ss_tready_i,
    input  logic                   sm_tvalid_i,
    input  wb_stream_pkg::sample_t sm_tdata_i,
    output logic                   sm_tready_o
);
    import wb_stream_pkg::*;

    wb_req_t  wb_req;
    ss_beat_t ss_beat;
    logic     x_push;
    sample_t  x_data;
    logic     x_empty;
    logic     y_full;
    sample_t  y_data;
    logic     y_pop;

    assign wb_req = '{
        cyc: wbs_cyc_i,
        stb: wbs_stb_i,
        we:  wbs_we_i,
        sel: wbs_sel_i,
        adr: wbs_adr_i,
        dat: wbs_dat_i
    };

    wb_port_ctrl #(.ACK_DELAY(ACK_DELAY)) u_ctrl (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .req_i     (wb_req),
        .x_empty_i (x_empty),
        .y_full_i  (y_full),
        .y_data_i  (y_data),
        .ack_o     (wbs_ack_o),
        .dat_o     (wbs_dat_o),
        .x_push_o  (x_push),
        .x_data_o  (x_data),
        .y_pop_o   (y_pop)
    );

    x_sample_buffer #(.FRAME_LEN(FRAME_LEN)) u_xbuf (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .push_i      (x_push),
        .data_i      (x_data),
        .ss_tready_i (ss_tready_i),
        .empty_o     (x_empty),
        .ss_beat_o   (ss_beat),
        .ss_tvalid_o (ss_tvalid_o)
    );

    y_sample_buffer u_ybuf (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .sm_tvalid_i (sm_tvalid_i),
        .sm_tdata_i  (sm_tdata_i),
        .pop_i       (y_pop),
        .sm_tready_o (sm_tready_o),
        .full_o      (y_full),
        .data_o      (y_data)
    );

    assign ss_tdata_o = ss_beat.data;
    assign ss_tlast_o = ss_beat.last;

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge, like every other input
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: test/tb_bridge.sv
module tb_bridge;
    timeunit 1ns;
    timeprecision 100ps;
    import wb_stream_pkg::*;

    localparam int ACK_DELAY      = 3;
    localparam int FRAME_LEN      = 4;
    localparam int ACK_EDGES      = ACK_DELAY + 2;   // one edge to accept, then delay and ack
    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [31:0] X_ADDR = {24'h300000, X_PORT_OFFSET};
    localparam logic [31:0] Y_ADDR = {24'h300000, Y_PORT_OFFSET};

    logic        wb_clk;
    logic        wb_rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    sample_t     wdat;
    logic        ack;
    sample_t     rdat;
    logic        ss_tvalid;
    sample_t     ss_tdata;
    logic        ss_tlast;
    logic        ss_tready;
    logic        sm_tvalid;
    sample_t     sm_tdata;
    logic        sm_tready;

    integer   seed;
    int       value_errors = 0;
    int       other_errors = 0;
    int       beats_seen = 0;
    int       lasts_seen = 0;
    int       cycle_cnt = 0;
    string    test_name = "reset";
    sample_t  x_log[$];   // every sample written to the x port, in order
    ss_beat_t exp_beat;

    tb_clock_gen u_clk (
        .clk_o (wb_clk),
        .rst_o (wb_rst)
    );

    wb_stream_bridge #(.ACK_DELAY(ACK_DELAY), .FRAME_LEN(FRAME_LEN)) uut (
        .wb_clk_i    (wb_clk),
        .wb_rst_i    (wb_rst),
        .wbs_cyc_i   (cyc),
        .wbs_stb_i   (stb),
        .wbs_we_i    (we),
        .wbs_sel_i   (sel),
        .wbs_adr_i   (adr),
        .wbs_dat_i   (wdat),
        .wbs_ack_o   (ack),
        .wbs_dat_o   (rdat),
        .ss_tvalid_o (ss_tvalid),
        .ss_tdata_o  (ss_tdata),
        .ss_tlast_o  (ss_tlast),
        .ss_tready_i (ss_tready),
        .sm_tvalid_i (sm_tvalid),
        .sm_tdata_i  (sm_tdata),
        .sm_tready_o (sm_tready)
    );

    // beat n is the n-th written sample, last closes every frame
    function automatic ss_beat_t expected_beat(input int n);
        ss_beat_t beat;
        beat.data = x_log[n];
        beat.last = ((n % FRAME_LEN) == (FRAME_LEN - 1));
        return beat;
    endfunction

    task automatic value_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        value_errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h",
                 test_name, what, expected, actual);
    endtask

    task automatic drive_access(input logic [31:0] addr, input sample_t data,
                                input logic write);
        @(posedge wb_clk);
        cyc  <= 1'b1;
        stb  <= 1'b1;
        we   <= write;
        sel  <= 4'hf;
        adr  <= addr;
        wdat <= data;
    endtask

    // edges counts rising edges from the drive edge up to the ack
    task automatic wait_for_ack(output int edges, output sample_t data);
        edges = 0;
        do begin
            @(posedge wb_clk);
            edges++;
            @(negedge wb_clk);
        end while (ack !== 1'b1);
        data = rdat;
        @(posedge wb_clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        @(negedge wb_clk);
        if (ack !== 1'b0) begin
            other_errors++;
            $display("%s: ack stayed high for more than one cycle", test_name);
        end
    endtask

    task automatic write_sample(input sample_t data);
        int      edges;
        sample_t rd;
        x_log.push_back(data);
        drive_access(X_ADDR, data, 1'b1);
        wait_for_ack(edges, rd);
        if (edges != ACK_EDGES) value_mismatch("ack edges", 32'(ACK_EDGES), 32'(edges));
        if (rd !== '0) value_mismatch("write read data", 32'h0, rd);
    endtask

    task automatic send_y_sample(input sample_t data);
        @(posedge wb_clk);
        sm_tvalid <= 1'b1;
        sm_tdata  <= data;
        do begin
            @(negedge wb_clk);
        end while (sm_tready !== 1'b1);
        @(posedge wb_clk);   // handshake edge
        sm_tvalid <= 1'b0;
    endtask

    task automatic check_no_ack(input int cycles);
        repeat (cycles) begin
            @(negedge wb_clk);
            if (ack !== 1'b0) begin
                other_errors++;
                $display("%s: ack arrived while the port was not ready", test_name);
            end
        end
    endtask

    task automatic wait_stream_idle;
        @(negedge wb_clk);
        while (ss_tvalid !== 1'b0) @(negedge wb_clk);
    endtask

    task automatic report_and_finish;
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // every ss handshake against the reference
    always @(negedge wb_clk) begin
        if (wb_rst !== 1'b1 && ss_tvalid === 1'b1 && ss_tready === 1'b1) begin
            if (beats_seen >= x_log.size()) begin
                other_errors++;
                $display("%s: ss beat %0d came out without a matching write",
                         test_name, beats_seen);
            end else begin
                exp_beat = expected_beat(beats_seen);
                if (ss_tdata !== exp_beat.data) value_mismatch("ss data", exp_beat.data, ss_tdata);
                if (ss_tlast !== exp_beat.last) begin
                    value_mismatch("ss last", 32'(exp_beat.last), 32'(ss_tlast));
                end
            end
            if (ss_tlast === 1'b1) lasts_seen++;
            beats_seen++;
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge wb_clk);
            cycle_cnt++;
        end
        other_errors++;
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_and_finish();
    end

    initial begin : main_seq
        sample_t d;
        sample_t rd;
        int      edges;
        seed      = 67561;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        sel       = 4'h0;
        adr       = '0;
        wdat      = '0;
        ss_tready = 1'b1;
        sm_tvalid = 1'b0;
        sm_tdata  = '0;

        @(negedge wb_clk);
        while (wb_rst === 1'b1) begin
            if (ack !== 1'b0 || ss_tvalid !== 1'b0) begin
                other_errors++;
                $display("reset: ack or ss_tvalid high during reset");
            end
            @(negedge wb_clk);
        end
        if (ack !== 1'b0) value_mismatch("ack", 32'h0, 32'(ack));
        if (ss_tvalid !== 1'b0) value_mismatch("ss_tvalid", 32'h0, 32'(ss_tvalid));
        if (sm_tready !== 1'b1) value_mismatch("sm_tready", 32'h1, 32'(sm_tready));
        if (rdat !== '0) value_mismatch("read data", 32'h0, rdat);

        test_name = "write_latency";
        repeat (4) begin
            d = $random(seed);
            write_sample(d);
        end

        test_name = "framing";
        repeat (8) begin
            d = $random(seed);
            write_sample(d);
        end
        wait_stream_idle();
        if (beats_seen != 12) value_mismatch("beat count", 32'd12, 32'(beats_seen));
        if (lasts_seen != 3) value_mismatch("last count", 32'd3, 32'(lasts_seen));

        test_name = "back_pressure";
        @(posedge wb_clk);
        ss_tready <= 1'b0;
        d = $random(seed);
        write_sample(d);
        d = $random(seed);
        x_log.push_back(d);
        drive_access(X_ADDR, d, 1'b1);
        check_no_ack(20);
        if (ss_tdata !== x_log[12]) value_mismatch("held ss data", x_log[12], ss_tdata);
        @(posedge wb_clk);
        ss_tready <= 1'b1;
        wait_for_ack(edges, rd);
        wait_stream_idle();
        if (beats_seen != 14) value_mismatch("beat count", 32'd14, 32'(beats_seen));

        test_name = "y_read";
        repeat (8) begin
            d = $random(seed);
            send_y_sample(d);
            drive_access(Y_ADDR, '0, 1'b0);
            wait_for_ack(edges, rd);
            if (edges != ACK_EDGES) value_mismatch("ack edges", 32'(ACK_EDGES), 32'(edges));
            if (rd !== d) value_mismatch("y data", d, rd);
        end

        test_name = "y_read_pending";
        drive_access(Y_ADDR, '0, 1'b0);
        check_no_ack(20);
        d = $random(seed);
        send_y_sample(d);
        wait_for_ack(edges, rd);
        if (rd !== d) value_mismatch("y data", d, rd);

        test_name = "final";
        if (beats_seen != x_log.size()) begin
            value_mismatch("beat count", 32'(x_log.size()), 32'(beats_seen));
        end
        report_and_finish();
    end

endmodule

// File: build.f
hw/wb_stream_pkg.sv
hw/x_sample_buffer.sv
hw/y_sample_buffer.sv
hw/wb_port_ctrl.sv
hw/wb_stream_bridge.sv
test/tb_clock_gen.sv
test/tb_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_bridge
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
